/* Makefile */
# Verilator build and run of the mini_core testbench.

VERILATOR ?= verilator
TOP       ?= tb_mini_core
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= test passed

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard *.sv)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FLIST OBJ_DIR VFLAGS PASS_TEXT"

$(BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

test: $(BIN)
	@out="$$(./$(BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* core_control.sv */
/*
 * Sequencer of the multicycle core. Steps FETCH, EXECUTE, optional MEMORY
 * and WRITEBACK, one state per cycle, and raises the phase strobes.
 */
`default_nettype none

module core_control
    import riscv_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  inst_class_e inst_class_i,
    output logic        ir_load_o,
    output logic        result_load_o,
    output logic        mem_access_o,
    output logic        reg_write_o,
    output logic        pc_update_o
);

    typedef enum logic [1:0] {
        FETCH,
        EXECUTE,
        MEMORY,
        WRITEBACK
    } state_e;

    state_e state;
    state_e next_state;
    logic   needs_mem;
    logic   writes_reg;

    assign needs_mem  = (inst_class_i == CLS_LOAD) || (inst_class_i == CLS_STORE);
    assign writes_reg = (inst_class_i == CLS_ALU) || (inst_class_i == CLS_LOAD)
                        || (inst_class_i == CLS_JAL);

    // ------------------------------
    // State register
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        case (state)
            FETCH:   next_state = EXECUTE;
            EXECUTE: next_state = needs_mem ? MEMORY : WRITEBACK;   // Only LW and SW go to memory.
            MEMORY:  next_state = WRITEBACK;
            default: next_state = FETCH;
        endcase
    end

    // Strobes are decoded from the state alone.
    assign ir_load_o     = (state == FETCH);
    assign result_load_o = (state == EXECUTE);
    assign mem_access_o  = (state == MEMORY);
    assign pc_update_o   = (state == WRITEBACK);
    assign reg_write_o   = (state == WRITEBACK) && writes_reg;

    // The decoded class must stay put while the memory phase runs.
    mem_only_for_access: assert property (@(posedge clk) disable iff (reset)
        mem_access_o |-> needs_mem);

endmodule

`default_nettype wire

/* execute_unit.sv */
/*
 * Operand selection, ALU, branch compare and the result register.
 * The result register also holds the memory address and the loaded word.
 */
`default_nettype none

module execute_unit
    import riscv_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    result_load_i,
    input  logic    mem_access_i,
    input  logic    is_load_i,
    input  logic    is_store_i,
    input  logic    is_bne_i,
    input  word_t   rs1_data_i,
    input  word_t   rs2_data_i,
    input  word_t   pc_i,
    input  word_t   imm_i,
    input  alu_op_e alu_op_i,
    input  logic    use_imm_i,
    input  logic    use_pc_i,
    output word_t   result_o,
    output logic    branch_taken_o,
    output word_t   mem_address_o,
    output word_t   mem_data_o,
    output logic    mem_enable_o,
    output logic    mem_write_o,
    input  word_t   mem_data_i
);

    word_t      op_a;
    word_t      op_b;
    word_t      alu_out;
    logic [4:0] shamt;

    // ------------------------------
    // Operands and ALU
    // ------------------------------
    assign op_a  = use_pc_i ? pc_i : rs1_data_i;
    assign op_b  = use_pc_i ? word_t'(4) : (use_imm_i ? imm_i : rs2_data_i);
    assign shamt = op_b[4:0];

    always_comb begin
        case (alu_op_i)
            ALU_SUB:    alu_out = op_a - op_b;
            ALU_SLT:    alu_out = word_t'($signed(op_a) < $signed(op_b));
            ALU_SLTU:   alu_out = word_t'(op_a < op_b);
            ALU_XOR:    alu_out = op_a ^ op_b;
            ALU_OR:     alu_out = op_a | op_b;
            ALU_AND:    alu_out = op_a & op_b;
            ALU_SLL:    alu_out = op_a << shamt;
            ALU_SRL:    alu_out = op_a >> shamt;
            ALU_SRA:    alu_out = word_t'($signed(op_a) >>> shamt);
            ALU_PASS_B: alu_out = op_b;
            default:    alu_out = op_a + op_b;
        endcase
    end

    // Loaded data replaces the address during MEMORY.
    always_ff @(posedge clk) begin
        if (reset) begin
            result_o <= '0;
        end else if (result_load_i) begin
            result_o <= alu_out;
        end else if (mem_access_i && is_load_i) begin
            result_o <= mem_data_i;
        end
    end

    assign branch_taken_o = (rs1_data_i == rs2_data_i) ^ is_bne_i;

    // ------------------------------
    // Data memory port
    // ------------------------------
    assign mem_enable_o  = mem_access_i && (is_load_i || is_store_i);
    assign mem_write_o   = mem_access_i && is_store_i;
    assign mem_address_o = result_o;
    assign mem_data_o    = rs2_data_i;

endmodule

`default_nettype wire

/* flist.f */
riscv_pkg.sv
core_control.sv
pc_counter.sv
inst_decoder.sv
reg_bank.sv
execute_unit.sv
mini_core.sv
tb_mini_core.sv

/* inst_decoder.sv */
/*
 * Instruction register and decoder. Captures the fetched word at the end
 * of FETCH and decodes register indices, immediate, ALU operation and class.
 */
`default_nettype none

module inst_decoder
    import riscv_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        ir_load_i,
    input  word_t       instruction_i,
    output reg_addr_t   rs1_o,
    output reg_addr_t   rs2_o,
    output reg_addr_t   rd_o,
    output word_t       imm_o,
    output alu_op_e     alu_op_o,
    output logic        use_imm_o,
    output logic        use_pc_o,
    output inst_class_e inst_class_o,
    output logic        is_branch_o,
    output logic        is_jal_o,
    output logic        is_bne_o
);

    instr_u ir;
    word_t  iw;
    word_t  imm_i_type;
    word_t  imm_s_type;
    word_t  imm_b_type;
    word_t  imm_u_type;
    word_t  imm_j_type;

    // A cleared register decodes as a no-op.
    always_ff @(posedge clk) begin
        if (reset) begin
            ir <= '0;
        end else if (ir_load_i) begin
            ir <= instruction_i;
        end
    end

    assign iw    = ir;
    assign rs1_o = ir.r.rs1;
    assign rs2_o = ir.r.rs2;
    assign rd_o  = ir.r.rd;

    // ------------------------------
    // Immediates
    // ------------------------------
    assign imm_i_type = {{20{iw[31]}}, iw[31:20]};
    assign imm_s_type = {{20{ir.s.imm_hi[6]}}, ir.s.imm_hi, ir.s.imm_lo};
    assign imm_b_type = {{19{iw[31]}}, iw[31], iw[7], iw[30:25], iw[11:8], 1'b0};
    assign imm_u_type = {iw[31:12], 12'b0};
    assign imm_j_type = {{11{iw[31]}}, iw[31], iw[19:12], iw[20], iw[30:21], 1'b0};

    // Maps funct3 to an ALU operation; alt is funct7 bit 5.
    function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt,
                                        input logic sub_ok);
        case (f3)
            3'b000:  alu_sel = (alt && sub_ok) ? ALU_SUB : ALU_ADD;
            3'b001:  alu_sel = ALU_SLL;
            3'b010:  alu_sel = ALU_SLT;
            3'b011:  alu_sel = ALU_SLTU;
            3'b100:  alu_sel = ALU_XOR;
            3'b101:  alu_sel = alt ? ALU_SRA : ALU_SRL;
            3'b110:  alu_sel = ALU_OR;
            default: alu_sel = ALU_AND;
        endcase
    endfunction

    // ------------------------------
    // Operation decode
    // ------------------------------
    always_comb begin
        imm_o        = imm_i_type;
        alu_op_o     = ALU_ADD;
        use_imm_o    = 1'b0;
        use_pc_o     = 1'b0;
        inst_class_o = CLS_NOP;
        is_branch_o  = 1'b0;
        is_jal_o     = 1'b0;
        is_bne_o     = 1'b0;
        case (ir.r.opcode)
            OPC_OP: begin
                // Only the base encodings; other funct7 values fall through as no-ops.
                if (ir.r.funct7 == 7'b0000000 || ir.r.funct7 == 7'b0100000) begin
                    inst_class_o = CLS_ALU;
                    alu_op_o     = alu_sel(ir.r.funct3, ir.r.funct7[5], 1'b1);
                end
            end
            OPC_OP_IMM: begin
                inst_class_o = CLS_ALU;
                use_imm_o    = 1'b1;
                alu_op_o     = alu_sel(ir.r.funct3, ir.r.funct7[5], 1'b0);
            end
            OPC_LUI: begin
                inst_class_o = CLS_ALU;
                use_imm_o    = 1'b1;
                imm_o        = imm_u_type;
                alu_op_o     = ALU_PASS_B;
            end
            OPC_LOAD: begin
                if (ir.r.funct3 == 3'b010) begin
                    inst_class_o = CLS_LOAD;       // Word loads only.
                    use_imm_o    = 1'b1;
                end
            end
            OPC_STORE: begin
                if (ir.s.funct3 == 3'b010) begin
                    inst_class_o = CLS_STORE;
                    use_imm_o    = 1'b1;
                    imm_o        = imm_s_type;
                end
            end
            OPC_BRANCH: begin
                if (ir.r.funct3[2:1] == 2'b00) begin
                    inst_class_o = CLS_BRANCH;     // BEQ and BNE.
                    is_branch_o  = 1'b1;
                    is_bne_o     = ir.r.funct3[0];
                    imm_o        = imm_b_type;
                end
            end
            OPC_JAL: begin
                inst_class_o = CLS_JAL;
                is_jal_o     = 1'b1;
                use_pc_o     = 1'b1;               // Link value is pc plus four.
                imm_o        = imm_j_type;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* mini_core.sv */
/*
 * Top level of the multicycle RV32I core. Connects the sequencer, program
 * counter, decoder, register file and execute unit to the two memory ports.
 */
`default_nettype none

module mini_core
    import riscv_pkg::*;
#(
    parameter word_t RESET_PC = '0
) (
    input  logic  clk,
    input  logic  reset,
    input  word_t instruction_i,
    input  word_t mem_data_i,
    output word_t instruction_address_o,
    output word_t mem_address_o,
    output word_t mem_data_o,
    output logic  mem_operation_enable_o,
    output logic  mem_write_o
);

    // ------------------------------
    // Internal nets
    // ------------------------------
    logic        ir_load;
    logic        result_load;
    logic        mem_access;
    logic        reg_write;
    logic        pc_update;
    inst_class_e inst_class;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    reg_addr_t   rd;
    word_t       imm;
    alu_op_e     alu_op;
    logic        use_imm;
    logic        use_pc;
    logic        is_branch;
    logic        is_jal;
    logic        is_bne;
    logic        is_load;
    logic        is_store;
    logic        branch_taken;
    word_t       pc;
    word_t       rs1_data;
    word_t       rs2_data;
    word_t       result;

    assign is_load               = (inst_class == CLS_LOAD);
    assign is_store              = (inst_class == CLS_STORE);
    assign instruction_address_o = pc;

    core_control u_control (
        .clk           (clk),
        .reset         (reset),
        .inst_class_i  (inst_class),
        .ir_load_o     (ir_load),
        .result_load_o (result_load),
        .mem_access_o  (mem_access),
        .reg_write_o   (reg_write),
        .pc_update_o   (pc_update)
    );

    pc_counter #(
        .RESET_PC (RESET_PC)
    ) u_pc (
        .clk            (clk),
        .reset          (reset),
        .pc_update_i    (pc_update),
        .is_jal_i       (is_jal),
        .is_branch_i    (is_branch),
        .branch_taken_i (branch_taken),
        .imm_i          (imm),
        .pc_o           (pc)
    );

    inst_decoder u_decoder (
        .clk           (clk),
        .reset         (reset),
        .ir_load_i     (ir_load),
        .instruction_i (instruction_i),
        .rs1_o         (rs1),
        .rs2_o         (rs2),
        .rd_o          (rd),
        .imm_o         (imm),
        .alu_op_o      (alu_op),
        .use_imm_o     (use_imm),
        .use_pc_o      (use_pc),
        .inst_class_o  (inst_class),
        .is_branch_o   (is_branch),
        .is_jal_o      (is_jal),
        .is_bne_o      (is_bne)
    );

    reg_bank u_regs (
        .clk     (clk),
        .reset   (reset),
        .we_i    (reg_write),
        .rs1_i   (rs1),
        .rs2_i   (rs2),
        .rd_i    (rd),
        .data_i  (result),
        .data1_o (rs1_data),
        .data2_o (rs2_data)
    );

    execute_unit u_execute (
        .clk            (clk),
        .reset          (reset),
        .result_load_i  (result_load),
        .mem_access_i   (mem_access),
        .is_load_i      (is_load),
        .is_store_i     (is_store),
        .is_bne_i       (is_bne),
        .rs1_data_i     (rs1_data),
        .rs2_data_i     (rs2_data),
        .pc_i           (pc),
        .imm_i          (imm),
        .alu_op_i       (alu_op),
        .use_imm_i      (use_imm),
        .use_pc_i       (use_pc),
        .result_o       (result),
        .branch_taken_o (branch_taken),
        .mem_address_o  (mem_address_o),
        .mem_data_o     (mem_data_o),
        .mem_enable_o   (mem_operation_enable_o),
        .mem_write_o    (mem_write_o),
        .mem_data_i     (mem_data_i)
    );

endmodule

`default_nettype wire

/* pc_counter.sv */
/*
 * Program counter. Advances by four at the end of WRITEBACK, or jumps to
 * pc plus the decoded offset for JAL and taken branches.
 */
`default_nettype none

module pc_counter
    import riscv_pkg::*;
#(
    parameter word_t RESET_PC = '0
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  pc_update_i,
    input  logic  is_jal_i,
    input  logic  is_branch_i,
    input  logic  branch_taken_i,
    input  word_t imm_i,
    output word_t pc_o
);

    logic redirect;

    assign redirect = is_jal_i || (is_branch_i && branch_taken_i);

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_o <= RESET_PC;
        end else if (pc_update_i) begin
            pc_o <= redirect ? pc_o + imm_i : pc_o + word_t'(4);
        end
    end

    // Branch and jump offsets from the decoder must keep fetches word aligned.
    pc_aligned: assert property (@(posedge clk) disable iff (reset) pc_o[1:0] == 2'b00);

endmodule

`default_nettype wire

/* reg_bank.sv */
/*
 * Register file of 32 words with two combinational read ports and one
 * write port. Register 0 always reads as zero.
 */
`default_nettype none

module reg_bank
    import riscv_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      we_i,
    input  reg_addr_t rs1_i,
    input  reg_addr_t rs2_i,
    input  reg_addr_t rd_i,
    input  word_t     data_i,
    output word_t     data1_o,
    output word_t     data2_o
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_i != '0) begin
            regs[rd_i] <= data_i;
        end
    end

    assign data1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign data2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

    // A write with an unknown index would corrupt an arbitrary register.
    write_index_known: assert property (@(posedge clk) disable iff (reset)
        we_i |-> !$isunknown(rd_i));

endmodule

`default_nettype wire

/* riscv_pkg.sv */
/*
 * Shared types and constants of the multicycle RV32I core.
 * Modules pull these in with a wildcard import in their headers.
 */
`default_nettype none

package riscv_pkg;

    // ------------------------------
    // Widths and basic types
    // ------------------------------
    localparam int XLEN = 32;

    typedef logic [4:0]      reg_addr_t;   // Register index.
    typedef logic [XLEN-1:0] word_t;       // Data and address word.

    // ------------------------------
    // Major opcodes
    // ------------------------------
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_PASS_B                         // Second operand straight through, for LUI.
    } alu_op_e;

    // What the sequencer needs to know about the instruction in flight.
    typedef enum logic [2:0] {
        CLS_ALU,
        CLS_LOAD,
        CLS_STORE,
        CLS_BRANCH,
        CLS_JAL,
        CLS_NOP
    } inst_class_e;

    // ------------------------------
    // Instruction word views
    // ------------------------------
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [6:0] imm_hi;                // Immediate bits 11 to 5.
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;                // Immediate bits 4 to 0.
        logic [6:0] opcode;
    } s_type_t;

    typedef union packed {
        r_type_t r;
        s_type_t s;
    } instr_u;

endpackage

`default_nettype wire

/* tb_mini_core.sv */
/*
 * Testbench of the multicycle RV32I core. Assembles a program with random
 * operands, models instruction and data memory, and checks every store.
 */
`default_nettype none

module tb_mini_core;

    localparam logic [31:0] RESET_PC    = 32'h0000_0200;
    localparam logic [31:0] STORE_BASE  = 32'h0000_0100;   // Results land here, one word each.
    localparam logic [31:0] LOAD_ADDR   = 32'h0000_0040;
    localparam logic [31:0] NOP         = 32'h0000_0013;   // addi x0, x0, 0
    localparam int          MAX_WAIT    = 100;
    localparam int          DRIVE_DELAY = 2;

    logic        clk;
    logic        reset;
    logic [31:0] instruction;
    logic [31:0] mem_rdata;
    logic [31:0] inst_addr;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic        mem_en;
    logic        mem_we;

    logic [31:0] imem [256];
    logic [31:0] dmem [128];
    string       exp_name [$];                              // Expected stores, in program order.
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    int          prog_len;
    integer      seed;

    mini_core #(
        .RESET_PC (RESET_PC)
    ) DUT (
        .clk                    (clk),
        .reset                  (reset),
        .instruction_i          (instruction),
        .mem_data_i             (mem_rdata),
        .instruction_address_o  (inst_addr),
        .mem_address_o          (mem_addr),
        .mem_data_o             (mem_wdata),
        .mem_operation_enable_o (mem_en),
        .mem_write_o            (mem_we)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ------------------------------
    // Instruction encoders
    // ------------------------------
    function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] itype(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] stype(input logic [11:0] imm, input logic [4:0] rs2);
        return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};   // sw rs2, imm(x0)
    endfunction

    function automatic logic [31:0] btype(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] utype(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] jtype(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    // ------------------------------
    // Reference arithmetic
    // ------------------------------
    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [31:0] shift_arith(input logic [31:0] v, input logic [4:0] n);
        logic [63:0] ext;
        ext = {{32{v[31]}}, v} >> n;                        // Sign bits shift in from above.
        return ext[31:0];
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5a5a_5a5a;
    endfunction

    function automatic logic [31:0] pc_now();
        return RESET_PC + 32'(4 * prog_len);
    endfunction

    // ------------------------------
    // Program building
    // ------------------------------
    task automatic emit(input logic [31:0] word);
        logic [31:0] addr;
        addr = pc_now();
        imem[addr[9:2]] = word;
        prog_len++;
    endtask

    task automatic emit_li(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] hi;
        hi = value + 32'h800;                               // Undo the sign of the low part.
        emit(utype(hi[31:12], rd));
        emit(itype(value[11:0], rd, 3'b000, rd, 7'b0010011));
    endtask

    task automatic add_store(input string name, input logic [4:0] rs2,
                             input logic [31:0] data);
        logic [31:0] addr;
        addr = STORE_BASE + 32'(4 * exp_addr.size());
        emit(stype(addr[11:0], rs2));
        exp_name.push_back(name);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic r_case(input string name, input logic [6:0] f7, input logic [2:0] f3,
                          input logic [4:0] rs1, input logic [4:0] rs2,
                          input logic [31:0] expected);
        emit(rtype(f7, rs2, rs1, f3, 5'd3));
        add_store(name, 5'd3, expected);
    endtask

    task automatic i_case(input string name, input logic [2:0] f3, input logic [11:0] imm,
                          input logic [31:0] expected);
        emit(itype(imm, 5'd1, f3, 5'd3, 7'b0010011));
        add_store(name, 5'd3, expected);
    endtask

    // Marker x7 ends as 0x11 if the branch skips the next instruction.
    task automatic branch_case(input string name, input logic [2:0] f3,
                               input logic [4:0] rs1, input logic [4:0] rs2, input logic taken);
        emit(itype(12'h011, 5'd0, 3'b000, 5'd7, 7'b0010011));
        emit(btype(13'd8, rs2, rs1, f3));
        emit(itype(12'h022, 5'd0, 3'b000, 5'd7, 7'b0010011));
        add_store(name, 5'd7, taken ? 32'h11 : 32'h22);
    endtask

    task automatic build_program();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        logic [31:0] rnd;
        logic [11:0] imm_a;
        logic [11:0] imm_b;
        logic [4:0]  shamt;
        logic [19:0] lui_imm;
        logic [31:0] link_pc;
        a = $random(seed);
        b = $random(seed);
        if (b == a) begin
            b = ~a;                                         // Branch cases need a != b.
        end
        c = a | 32'h8000_0000;
        d = b & 32'h7fff_ffff;
        rnd = $random(seed);
        imm_a = rnd[11:0];
        imm_b = rnd[23:12];
        shamt = rnd[28:24];
        rnd = $random(seed);
        lui_imm = rnd[31:12];

        emit_li(5'd1, a);
        emit_li(5'd2, b);
        emit_li(5'd9, c);
        emit_li(5'd10, d);
        add_store("li_a", 5'd1, a);
        add_store("li_b", 5'd2, b);

        r_case("add", 7'h00, 3'b000, 5'd1, 5'd2, a + b);
        r_case("sub", 7'h20, 3'b000, 5'd1, 5'd2, a - b);
        r_case("sll", 7'h00, 3'b001, 5'd1, 5'd2, a << b[4:0]);
        r_case("slt", 7'h00, 3'b010, 5'd1, 5'd2, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        r_case("sltu", 7'h00, 3'b011, 5'd1, 5'd2, (a < b) ? 32'd1 : 32'd0);
        r_case("slt_neg", 7'h00, 3'b010, 5'd9, 5'd10, ($signed(c) < $signed(d)) ? 32'd1 : 32'd0);
        r_case("sltu_neg", 7'h00, 3'b011, 5'd9, 5'd10, (c < d) ? 32'd1 : 32'd0);
        r_case("xor", 7'h00, 3'b100, 5'd1, 5'd2, a ^ b);
        r_case("srl", 7'h00, 3'b101, 5'd1, 5'd2, a >> b[4:0]);
        r_case("sra", 7'h20, 3'b101, 5'd1, 5'd2, shift_arith(a, b[4:0]));
        r_case("or", 7'h00, 3'b110, 5'd1, 5'd2, a | b);
        r_case("and", 7'h00, 3'b111, 5'd1, 5'd2, a & b);

        i_case("addi", 3'b000, imm_a, a + sext12(imm_a));
        i_case("slti", 3'b010, imm_a, ($signed(a) < $signed(sext12(imm_a))) ? 32'd1 : 32'd0);
        i_case("sltiu", 3'b011, imm_a, (a < sext12(imm_a)) ? 32'd1 : 32'd0);
        i_case("xori", 3'b100, imm_b, a ^ sext12(imm_b));
        i_case("ori", 3'b110, imm_b, a | sext12(imm_b));
        i_case("andi", 3'b111, imm_b, a & sext12(imm_b));
        i_case("slli", 3'b001, {7'h00, shamt}, a << shamt);
        i_case("srli", 3'b101, {7'h00, shamt}, a >> shamt);
        i_case("srai", 3'b101, {7'h20, shamt}, shift_arith(a, shamt));

        emit(utype(lui_imm, 5'd4));
        add_store("lui", 5'd4, {lui_imm, 12'h000});
        emit(rtype(7'h00, 5'd2, 5'd1, 3'b000, 5'd0));       // add x0, x1, x2
        add_store("x0_write", 5'd0, 32'd0);

        emit(itype(LOAD_ADDR[11:0], 5'd0, 3'b010, 5'd5, 7'b0000011));
        add_store("lw_fill", 5'd5, fill_word(LOAD_ADDR));
        emit(itype(STORE_BASE[11:0], 5'd0, 3'b010, 5'd6, 7'b0000011));
        add_store("lw_stored", 5'd6, a);                    // Reads back the li_a store.

        branch_case("beq_taken", 3'b000, 5'd1, 5'd1, 1'b1);
        branch_case("beq_not", 3'b000, 5'd1, 5'd2, 1'b0);
        branch_case("bne_taken", 3'b001, 5'd1, 5'd2, 1'b1);
        branch_case("bne_not", 3'b001, 5'd1, 5'd1, 1'b0);

        emit(itype(12'h033, 5'd0, 3'b000, 5'd7, 7'b0010011));
        link_pc = pc_now() + 32'd4;
        emit(jtype(21'd8, 5'd8));
        emit(itype(12'h044, 5'd0, 3'b000, 5'd7, 7'b0010011));
        add_store("jal_link", 5'd8, link_pc);
        add_store("jal_skip", 5'd7, 32'h33);
        emit(jtype(21'd0, 5'd0));                           // Park here.
    endtask

    // ------------------------------
    // Checking
    // ------------------------------
    task automatic abort_run();
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("error %s: expected %h, actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic wait_pc_step(input string name, input logic [31:0] expected,
                                input logic check_cycles);
        logic [31:0] start;
        int          cycles;
        start = inst_addr;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (inst_addr == start && cycles < MAX_WAIT);
        if (inst_addr == start) begin
            $display("timeout: instruction address stayed at %h during %s", start, name);
            abort_run();
        end
        check_value(name, expected, inst_addr);
        if (check_cycles) begin
            check_value({name, "_cycles"}, 32'd3, 32'(cycles));   // Non-memory step.
        end
    endtask

    task automatic wait_store(input int idx);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!(mem_en && mem_we) && cycles < MAX_WAIT);
        if (!(mem_en && mem_we)) begin
            $display("timeout: store %0d (%s) never reached the data port", idx, exp_name[idx]);
            abort_run();
        end
        check_value({exp_name[idx], "_addr"}, exp_addr[idx], mem_addr);
        check_value({exp_name[idx], "_data"}, exp_data[idx], mem_wdata);
    endtask

    // ------------------------------
    // Memory models
    // ------------------------------
    initial begin
        instruction = NOP;
        mem_rdata = '0;
        forever begin
            @(posedge clk);
            #DRIVE_DELAY;
            instruction = imem[inst_addr[9:2]];
            mem_rdata = dmem[mem_addr[8:2]];
        end
    end

    initial begin
        for (int i = 0; i < 128; i++) begin
            dmem[i] = fill_word(32'(i) << 2);
        end
        forever begin
            @(negedge clk);
            if (mem_we && !mem_en) begin
                $display("mem_write_o went high without mem_operation_enable_o");
                abort_run();
            end else if (mem_en && mem_we) begin
                dmem[mem_addr[8:2]] = mem_wdata;
            end
        end
    end

    initial begin
        reset = 1'b1;
        seed = 43;
        prog_len = 0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = NOP;
        end
        build_program();

        repeat (16) @(posedge clk);
        #DRIVE_DELAY;
        check_value("reset_pc", RESET_PC, inst_addr);
        check_value("reset_mem_enable", 32'd0, {31'd0, mem_en});
        check_value("reset_mem_write", 32'd0, {31'd0, mem_we});
        reset = 1'b0;

        wait_pc_step("pc_step_1", RESET_PC + 32'd4, 1'b0);
        wait_pc_step("pc_step_2", RESET_PC + 32'd8, 1'b1);
        wait_pc_step("pc_step_3", RESET_PC + 32'd12, 1'b1);

        for (int k = 0; k < exp_name.size(); k++) begin
            wait_store(k);
        end
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire
